//--- rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    localparam logic [31:0] reset_pc = 32'h0000_0000;

    // ADDI x0, x0, 0
    localparam logic [31:0] nop_instr = 32'h0000_0013;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_lui    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    // Source of a decode operand
    typedef enum logic [1:0] {
        fwd_rf,
        fwd_ex,
        fwd_mem
    } fwd_sel_e;

endpackage

//--- if_stage.sv
`timescale 1ns/1ps

module if_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    freeze,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    jump,
    input  logic [rv_pkg::xlen-1:0] target,
    input  logic [rv_pkg::xlen-1:0] idt,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] pc_id,
    output logic [rv_pkg::xlen-1:0] pc4_id,
    output logic [rv_pkg::xlen-1:0] instr_id
);

    logic [rv_pkg::xlen-1:0] pc4;
    logic [rv_pkg::xlen-1:0] next_pc;

    assign pc4     = pc + 32'd4;
    assign next_pc = jump ? target : pc4;

    // A taken jump overrides a load-use hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= rv_pkg::reset_pc;
        end else if (!freeze && (jump || !stall)) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_id <= rv_pkg::nop_instr;
        end else if (!freeze) begin
            if (flush) begin
                instr_id <= rv_pkg::nop_instr;
            end else if (!stall) begin
                instr_id <= idt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && !stall) begin
            pc_id  <= pc;
            pc4_id <= pc4;
        end
    end

endmodule

//--- id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    freeze,
    input  logic                    stall,
    input  logic                    flush,
    input  logic [rv_pkg::xlen-1:0] pc_id,
    input  logic [rv_pkg::xlen-1:0] pc4_id,
    input  logic [rv_pkg::xlen-1:0] instr_id,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    input  logic [rv_pkg::xlen-1:0] rf_data1,
    input  logic [rv_pkg::xlen-1:0] rf_data2,
    input  rv_pkg::fwd_sel_e        fwd1,
    input  rv_pkg::fwd_sel_e        fwd2,
    input  logic [rv_pkg::xlen-1:0] ex_result,
    input  logic [rv_pkg::xlen-1:0] mem_result,
    output rv_pkg::opcode_e         opcode_ex,
    output rv_pkg::alu_op_e         alu_op_ex,
    output logic [2:0]              funct3_ex,
    output logic [4:0]              rd_ex,
    output logic                    reg_write_ex,
    output logic [rv_pkg::xlen-1:0] op_a_ex,
    output logic [rv_pkg::xlen-1:0] op_b_ex,
    output logic [rv_pkg::xlen-1:0] store_data_ex,
    output logic [rv_pkg::xlen-1:0] imm_ex,
    output logic [rv_pkg::xlen-1:0] pc_ex,
    output logic [rv_pkg::xlen-1:0] pc4_ex,
    output logic                    use_imm_ex
);

    rv_pkg::opcode_e         opcode;
    rv_pkg::alu_op_e         alu_f3;
    rv_pkg::alu_op_e         alu_op;
    logic                    reg_write;
    logic                    use_imm;
    logic [rv_pkg::xlen-1:0] imm;
    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;

    function automatic logic [31:0] pick(input rv_pkg::fwd_sel_e sel, input logic [31:0] rf_val,
                                         input logic [31:0] ex_val, input logic [31:0] mem_val);
        case (sel)
            rv_pkg::fwd_ex:  return ex_val;
            rv_pkg::fwd_mem: return mem_val;
            default:         return rf_val;
        endcase
    endfunction

    assign opcode = rv_pkg::opcode_e'(instr_id[6:0]);
    assign rs1    = instr_id[19:15];
    assign rs2    = instr_id[24:20];
    assign op_a   = pick(fwd1, rf_data1, ex_result, mem_result);
    assign op_b   = pick(fwd2, rf_data2, ex_result, mem_result);

    always_comb begin
        case (instr_id[14:12])
            3'b010:  alu_f3 = rv_pkg::alu_slt;
            3'b100:  alu_f3 = rv_pkg::alu_xor;
            3'b110:  alu_f3 = rv_pkg::alu_or;
            3'b111:  alu_f3 = rv_pkg::alu_and;
            default: alu_f3 = rv_pkg::alu_add;
        endcase
    end

    always_comb begin
        alu_op    = rv_pkg::alu_add;
        reg_write = 1'b0;
        use_imm   = 1'b0;
        imm       = {{20{instr_id[31]}}, instr_id[31:20]};
        case (opcode)
            rv_pkg::op_reg: begin
                reg_write = 1'b1;
                // funct7 bit 30 selects SUB
                alu_op = (instr_id[14:12] == 3'b000 && instr_id[30]) ? rv_pkg::alu_sub : alu_f3;
            end
            rv_pkg::op_imm: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_op    = alu_f3;
            end
            rv_pkg::op_load: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
            end
            rv_pkg::op_store: begin
                use_imm = 1'b1;
                imm     = {{20{instr_id[31]}}, instr_id[31:25], instr_id[11:7]};
            end
            rv_pkg::op_branch: begin
                imm = {{19{instr_id[31]}}, instr_id[31], instr_id[7], instr_id[30:25],
                       instr_id[11:8], 1'b0};
            end
            rv_pkg::op_jal: begin
                reg_write = 1'b1;
                imm = {{11{instr_id[31]}}, instr_id[31], instr_id[19:12], instr_id[20],
                       instr_id[30:21], 1'b0};
            end
            rv_pkg::op_lui: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_op    = rv_pkg::alu_pass_b;
                imm       = {instr_id[31:12], 12'd0};
            end
            default: ;
        endcase
    end

    // Bubble in ID/EX is an ADDI that writes nothing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opcode_ex    <= rv_pkg::op_imm;
            rd_ex        <= 5'd0;
            reg_write_ex <= 1'b0;
        end else if (!freeze) begin
            if (stall || flush) begin
                opcode_ex    <= rv_pkg::op_imm;
                rd_ex        <= 5'd0;
                reg_write_ex <= 1'b0;
            end else begin
                opcode_ex    <= opcode;
                rd_ex        <= instr_id[11:7];
                reg_write_ex <= reg_write;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            alu_op_ex     <= alu_op;
            funct3_ex     <= instr_id[14:12];
            op_a_ex       <= op_a;
            op_b_ex       <= op_b;
            store_data_ex <= op_b;
            imm_ex        <= imm;
            pc_ex         <= pc_id;
            pc4_ex        <= pc4_id;
            use_imm_ex    <= use_imm;
        end
    end

endmodule

//--- rf32x32.sv
`timescale 1ns/1ps

module rf32x32 (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              wb_rd,
    input  logic                    wb_we,
    input  logic [rv_pkg::xlen-1:0] wb_data,
    output logic [rv_pkg::xlen-1:0] rf_data1,
    output logic [rv_pkg::xlen-1:0] rf_data2
);

    logic [rv_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rf_data1 = (rs1 == 5'd0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rf_data2 = (rs2 == 5'd0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

//--- ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    freeze,
    input  rv_pkg::opcode_e         opcode_ex,
    input  rv_pkg::alu_op_e         alu_op_ex,
    input  logic [2:0]              funct3_ex,
    input  logic [4:0]              rd_ex,
    input  logic                    reg_write_ex,
    input  logic [rv_pkg::xlen-1:0] op_a_ex,
    input  logic [rv_pkg::xlen-1:0] op_b_ex,
    input  logic [rv_pkg::xlen-1:0] store_data_ex,
    input  logic [rv_pkg::xlen-1:0] imm_ex,
    input  logic [rv_pkg::xlen-1:0] pc_ex,
    input  logic [rv_pkg::xlen-1:0] pc4_ex,
    input  logic                    use_imm_ex,
    output logic [rv_pkg::xlen-1:0] ex_result,
    output logic                    jump,
    output logic [rv_pkg::xlen-1:0] target,
    output logic                    is_load,
    output rv_pkg::opcode_e         opcode_mem,
    output logic [rv_pkg::xlen-1:0] alu_result_mem,
    output logic [rv_pkg::xlen-1:0] store_data_mem,
    output logic [4:0]              rd_mem,
    output logic                    reg_write_mem,
    output logic [rv_pkg::xlen-1:0] pc4_mem
);

    logic [rv_pkg::xlen-1:0] alu_b;
    logic [rv_pkg::xlen-1:0] alu_y;
    logic                    taken;

    assign alu_b = use_imm_ex ? imm_ex : op_b_ex;

    always_comb begin
        case (alu_op_ex)
            rv_pkg::alu_sub:    alu_y = op_a_ex - alu_b;
            rv_pkg::alu_and:    alu_y = op_a_ex & alu_b;
            rv_pkg::alu_or:     alu_y = op_a_ex | alu_b;
            rv_pkg::alu_xor:    alu_y = op_a_ex ^ alu_b;
            rv_pkg::alu_slt:    alu_y = {31'd0, $signed(op_a_ex) < $signed(alu_b)};
            rv_pkg::alu_pass_b: alu_y = alu_b;
            default:            alu_y = op_a_ex + alu_b;
        endcase
    end

    // BEQ, BNE, BLT, BGE
    always_comb begin
        case (funct3_ex)
            3'b000:  taken = op_a_ex == op_b_ex;
            3'b001:  taken = op_a_ex != op_b_ex;
            3'b100:  taken = $signed(op_a_ex) < $signed(op_b_ex);
            3'b101:  taken = $signed(op_a_ex) >= $signed(op_b_ex);
            default: taken = 1'b0;
        endcase
    end

    assign jump      = (opcode_ex == rv_pkg::op_branch && taken) || opcode_ex == rv_pkg::op_jal;
    assign target    = pc_ex + imm_ex;
    assign is_load   = opcode_ex == rv_pkg::op_load;
    // Link value for JAL
    assign ex_result = (opcode_ex == rv_pkg::op_jal) ? pc4_ex : alu_y;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opcode_mem    <= rv_pkg::op_imm;
            rd_mem        <= 5'd0;
            reg_write_mem <= 1'b0;
        end else if (!freeze) begin
            opcode_mem    <= opcode_ex;
            rd_mem        <= rd_ex;
            reg_write_mem <= reg_write_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            alu_result_mem <= alu_y;
            store_data_mem <= store_data_ex;
            pc4_mem        <= pc4_ex;
        end
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    freeze,
    input  rv_pkg::opcode_e         opcode_mem,
    input  logic [rv_pkg::xlen-1:0] alu_result_mem,
    input  logic [rv_pkg::xlen-1:0] store_data_mem,
    input  logic [4:0]              rd_mem,
    input  logic                    reg_write_mem,
    input  logic [rv_pkg::xlen-1:0] pc4_mem,
    input  logic [rv_pkg::xlen-1:0] ddt_in,
    output logic                    mreq,
    output logic                    write,
    output logic [rv_pkg::xlen-1:0] dad,
    output logic [rv_pkg::xlen-1:0] store_data,
    output logic [rv_pkg::xlen-1:0] mem_result,
    output logic [4:0]              wb_rd,
    output logic                    wb_we,
    output logic [rv_pkg::xlen-1:0] wb_data
);

    logic is_load;
    logic wb_we_q;

    assign is_load    = opcode_mem == rv_pkg::op_load;
    assign write      = opcode_mem == rv_pkg::op_store;
    assign mreq       = is_load || write;
    assign dad        = alu_result_mem;
    assign store_data = store_data_mem;

    always_comb begin
        if (is_load) begin
            mem_result = ddt_in;
        end else if (opcode_mem == rv_pkg::op_jal) begin
            mem_result = pc4_mem;
        end else begin
            mem_result = alu_result_mem;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rd   <= 5'd0;
            wb_we_q <= 1'b0;
        end else if (!freeze) begin
            wb_rd   <= rd_mem;
            wb_we_q <= reg_write_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            wb_data <= mem_result;
        end
    end

    // Retire only on the edge that ends the freeze
    assign wb_we = wb_we_q && !freeze;

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  rv_pkg::opcode_e  opcode_id,
    input  logic [4:0]       rd_ex,
    input  logic             reg_write_ex,
    input  logic             is_load,
    input  logic [4:0]       rd_mem,
    input  logic             reg_write_mem,
    input  logic             jump,
    input  logic             acki_n,
    input  logic             ackd_n,
    input  logic             mreq,
    output rv_pkg::fwd_sel_e fwd1,
    output rv_pkg::fwd_sel_e fwd2,
    output logic             stall,
    output logic             flush,
    output logic             freeze
);

    logic uses_rs1;
    logic uses_rs2;

    // Youngest producer wins
    function automatic rv_pkg::fwd_sel_e fwd_pick(input logic [4:0] rs, input logic [4:0] rd_e,
                                                  input logic we_e, input logic [4:0] rd_m,
                                                  input logic we_m);
        if (rs == 5'd0) begin
            return rv_pkg::fwd_rf;
        end
        if (we_e && rd_e == rs) begin
            return rv_pkg::fwd_ex;
        end
        if (we_m && rd_m == rs) begin
            return rv_pkg::fwd_mem;
        end
        return rv_pkg::fwd_rf;
    endfunction

    assign fwd1 = fwd_pick(rs1, rd_ex, reg_write_ex, rd_mem, reg_write_mem);
    assign fwd2 = fwd_pick(rs2, rd_ex, reg_write_ex, rd_mem, reg_write_mem);

    assign uses_rs1 = opcode_id != rv_pkg::op_lui && opcode_id != rv_pkg::op_jal;
    assign uses_rs2 = opcode_id == rv_pkg::op_reg || opcode_id == rv_pkg::op_store ||
                      opcode_id == rv_pkg::op_branch;

    // Load data is not ready until MEM
    assign stall = is_load && reg_write_ex && rd_ex != 5'd0 &&
                   ((uses_rs1 && rs1 == rd_ex) || (uses_rs2 && rs2 == rd_ex));

    assign flush  = jump;
    assign freeze = acki_n || (mreq && ackd_n);

endmodule

//--- top.sv
`timescale 1ns/1ps

module top (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [rv_pkg::xlen-1:0] iad,
    input  logic [rv_pkg::xlen-1:0] idt,
    input  logic                    acki_n,
    output logic [rv_pkg::xlen-1:0] dad,
    inout  wire  [rv_pkg::xlen-1:0] ddt,
    output logic                    mreq,
    output logic                    write,
    input  logic                    ackd_n
);

    // IF/ID
    logic [rv_pkg::xlen-1:0] pc_id;
    logic [rv_pkg::xlen-1:0] pc4_id;
    logic [rv_pkg::xlen-1:0] instr_id;
    rv_pkg::opcode_e         opcode_id;

    // Decode operands
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [rv_pkg::xlen-1:0] rf_data1;
    logic [rv_pkg::xlen-1:0] rf_data2;
    rv_pkg::fwd_sel_e        fwd1;
    rv_pkg::fwd_sel_e        fwd2;

    // ID/EX
    rv_pkg::opcode_e         opcode_ex;
    rv_pkg::alu_op_e         alu_op_ex;
    logic [2:0]              funct3_ex;
    logic [4:0]              rd_ex;
    logic                    reg_write_ex;
    logic [rv_pkg::xlen-1:0] op_a_ex;
    logic [rv_pkg::xlen-1:0] op_b_ex;
    logic [rv_pkg::xlen-1:0] store_data_ex;
    logic [rv_pkg::xlen-1:0] imm_ex;
    logic [rv_pkg::xlen-1:0] pc_ex;
    logic [rv_pkg::xlen-1:0] pc4_ex;
    logic                    use_imm_ex;

    // EX
    logic [rv_pkg::xlen-1:0] ex_result;
    logic                    jump;
    logic [rv_pkg::xlen-1:0] target;
    logic                    is_load;

    // EX/MEM
    rv_pkg::opcode_e         opcode_mem;
    logic [rv_pkg::xlen-1:0] alu_result_mem;
    logic [rv_pkg::xlen-1:0] store_data_mem;
    logic [4:0]              rd_mem;
    logic                    reg_write_mem;
    logic [rv_pkg::xlen-1:0] pc4_mem;

    // MEM and writeback
    logic [rv_pkg::xlen-1:0] ddt_in;
    logic [rv_pkg::xlen-1:0] store_data;
    logic [rv_pkg::xlen-1:0] mem_result;
    logic [4:0]              wb_rd;
    logic                    wb_we;
    logic [rv_pkg::xlen-1:0] wb_data;

    logic stall;
    logic flush;
    logic freeze;

    assign opcode_id = rv_pkg::opcode_e'(instr_id[6:0]);

    // Data bus is driven only while a store is in MEM
    assign ddt    = write ? store_data : 'z;
    assign ddt_in = ddt;

    if_stage if_stage_i (.pc(iad), .*);

    id_stage id_stage_i (.*);

    rf32x32 rf32x32_i (.*);

    ex_stage ex_stage_i (.*);

    mem_stage mem_stage_i (.*);

    hazard_unit hazard_unit_i (.*);

endmodule

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int reset_cycles = 4;
    localparam int max_ack_wait = 2;

    logic        clk;
    logic        rst_n;
    logic [31:0] iad;
    logic [31:0] idt;
    logic        acki_n;
    logic [31:0] dad;
    wire  [31:0] ddt;
    logic        mreq;
    logic        write;
    logic        ackd_n;

    logic [31:0] rom [64];
    logic [31:0] ram [64];
    logic [31:0] exp_addr [64];
    logic [31:0] exp_data [64];
    int          n_exp;
    int          prog_len;
    logic [31:0] halt_pc;

    logic [31:0] seed;
    logic [1:0]  i_wait;
    logic [1:0]  d_wait;
    logic        advanced;
    logic        drive_ddt;
    logic [31:0] load_word;
    wire         advance;
    wire         store_fire;

    int cycles;
    int cycle_limit;
    int adv_count;
    int st_idx;
    int mark;
    int store_errors;
    int other_errors;

    top top_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .iad    (iad),
        .idt    (idt),
        .acki_n (acki_n),
        .dad    (dad),
        .ddt    (ddt),
        .mreq   (mreq),
        .write  (write),
        .ackd_n (ackd_n)
    );

    // The pipeline moves on a rising edge only with both acknowledges in
    assign advance    = !acki_n && !(mreq && ackd_n);
    assign store_fire = rst_n && advance && mreq && write;
    assign ddt        = (drive_ddt && mreq && !write) ? load_word : 'z;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] ram_fill(input int k);
        return 32'h5a5a_0000 | (32'(k) << 2);
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input rv_pkg::opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], rv_pkg::op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_pkg::op_lui};
    endfunction

    // Bit 30 of the instruction turns ADD into SUB
    function automatic logic [31:0] arith_result(input logic [2:0] f3, input logic sub,
                                                 input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    task automatic emit(input logic [31:0] ins);
        rom[prog_len] = ins;
        prog_len++;
    endtask

    task automatic load_program();
        for (int k = 0; k < 64; k++) begin
            rom[k] = rv_pkg::nop_instr;
        end
        prog_len = 0;
        // Dependent ALU chain
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, rv_pkg::op_imm));
        emit(i_type(12'd7, 5'd1, 3'b000, 5'd2, rv_pkg::op_imm));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        emit(r_type(7'h00, 5'd3, 5'd4, 3'b100, 5'd5));
        emit(s_type(12'd0, 5'd3, 5'd0));
        emit(s_type(12'd4, 5'd4, 5'd0));
        emit(s_type(12'd8, 5'd5, 5'd0));
        // Load-use pairs
        emit(i_type(12'd0, 5'd0, 3'b010, 5'd6, rv_pkg::op_load));
        emit(r_type(7'h00, 5'd2, 5'd6, 3'b000, 5'd7));
        emit(s_type(12'd12, 5'd7, 5'd0));
        emit(i_type(12'd4, 5'd0, 3'b010, 5'd8, rv_pkg::op_load));
        emit(s_type(12'd16, 5'd8, 5'd0));
        // Taken BEQ, BNE and JAL each skip one store
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b000));
        emit(s_type(12'd20, 5'd1, 5'd0));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b001));
        emit(s_type(12'd24, 5'd2, 5'd0));
        emit(j_type(21'd8, 5'd9));
        emit(s_type(12'd28, 5'd3, 5'd0));
        emit(s_type(12'd32, 5'd9, 5'd0));
        // Not taken BLT and BGE
        emit(b_type(13'd8, 5'd1, 5'd2, 3'b100));
        emit(s_type(12'd36, 5'd1, 5'd0));
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b101));
        emit(s_type(12'd40, 5'd2, 5'd0));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd10));
        emit(i_type(12'h030, 5'd10, 3'b110, 5'd11, rv_pkg::op_imm));
        emit(i_type(12'h021, 5'd11, 3'b111, 5'd12, rv_pkg::op_imm));
        emit(i_type(12'hfff, 5'd12, 3'b100, 5'd13, rv_pkg::op_imm));
        emit(u_type(20'h12345, 5'd14));
        emit(r_type(7'h00, 5'd13, 5'd14, 3'b110, 5'd15));
        emit(r_type(7'h00, 5'd11, 5'd15, 3'b111, 5'd16));
        emit(s_type(12'd44, 5'd13, 5'd0));
        emit(s_type(12'd48, 5'd15, 5'd0));
        emit(s_type(12'd52, 5'd16, 5'd0));
        emit(j_type(21'd0, 5'd0));
        halt_pc = 32'(prog_len - 1) << 2;
    endtask

    // Runs the program one instruction at a time and records every store
    function automatic void build_expected();
        logic [31:0] r [32];
        logic [31:0] m [64];
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] addr;
        logic [4:0]  rd;
        logic        done;
        for (int k = 0; k < 32; k++) begin
            r[k] = '0;
        end
        for (int k = 0; k < 64; k++) begin
            m[k] = ram_fill(k);
        end
        pc    = rv_pkg::reset_pc;
        n_exp = 0;
        done  = 1'b0;
        for (int step = 0; step < 512 && !done; step++) begin
            ins     = rom[pc[7:2]];
            a       = r[ins[19:15]];
            b       = r[ins[24:20]];
            rd      = ins[11:7];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            pc_next = pc + 32'd4;
            case (rv_pkg::opcode_e'(ins[6:0]))
                rv_pkg::op_reg:   r[rd] = arith_result(ins[14:12], ins[30], a, b);
                rv_pkg::op_imm:   r[rd] = arith_result(ins[14:12], 1'b0, a, imm_i);
                rv_pkg::op_lui:   r[rd] = {ins[31:12], 12'd0};
                rv_pkg::op_load: begin
                    addr  = a + imm_i;
                    r[rd] = m[addr[7:2]];
                end
                rv_pkg::op_store: begin
                    addr            = a + imm_s;
                    m[addr[7:2]]    = b;
                    exp_addr[n_exp] = addr;
                    exp_data[n_exp] = b;
                    n_exp++;
                end
                rv_pkg::op_branch: begin
                    if (branch_cond(ins[14:12], a, b)) begin
                        pc_next = pc + imm_b;
                    end
                end
                rv_pkg::op_jal: begin
                    r[rd]   = pc + 32'd4;
                    pc_next = pc + imm_j;
                    done    = imm_j == 32'd0;
                end
                default: ;
            endcase
            r[0] = '0;
            pc   = pc_next;
        end
    endfunction

    task automatic finish_run();
        $display("store errors %0d, other errors %0d, stores seen %0d of %0d",
                 store_errors, other_errors, st_idx, n_exp);
        if (store_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles   <= cycles + 1;
        advanced <= advance;
        if (rst_n && advance) begin
            adv_count <= adv_count + 1;
        end
        if (store_fire) begin
            ram[dad[7:2]] <= ddt;
        end
    end

    // Memory models draw a fresh wait of 0 to 2 cycles per access
    always @(negedge clk) begin
        if (advanced) begin
            seed   = xorshift(seed);
            i_wait = 2'(seed % 32'd3);
            seed   = xorshift(seed);
            d_wait = 2'(seed % 32'd3);
        end else begin
            if (i_wait != 2'd0) begin
                i_wait = i_wait - 2'd1;
            end
            if (d_wait != 2'd0) begin
                d_wait = d_wait - 2'd1;
            end
        end
        acki_n    <= i_wait != 2'd0;
        idt       <= rom[iad[7:2]];
        ackd_n    <= !(mreq && d_wait == 2'd0);
        drive_ddt <= mreq && !write && d_wait == 2'd0;
        load_word <= ram[dad[7:2]];
    end

    // Store stream against the expected list
    always @(posedge clk) begin
        if (store_fire) begin
            assert (st_idx < n_exp) else begin
                other_errors++;
                $display("unexpected extra store to address %h", dad);
            end
            if (st_idx < n_exp) begin
                assert (dad == exp_addr[st_idx]) else begin
                    store_errors++;
                    $display("error dad got %h expected %h", dad, exp_addr[st_idx]);
                end
                assert (ddt === exp_data[st_idx]) else begin
                    store_errors++;
                    $display("error ddt got %h expected %h", ddt, exp_data[st_idx]);
                end
            end
            st_idx <= st_idx + 1;
        end
    end

    initial begin
        rst_n        = 1'b0;
        idt          = rv_pkg::nop_instr;
        acki_n       = 1'b1;
        ackd_n       = 1'b1;
        drive_ddt    = 1'b0;
        load_word    = '0;
        seed         = 32'he6328b74;
        i_wait       = 2'd0;
        d_wait       = 2'd0;
        advanced     = 1'b1;
        cycles       = 0;
        cycle_limit  = 0;
        adv_count    = 0;
        st_idx       = 0;
        store_errors = 0;
        other_errors = 0;
        for (int k = 0; k < 64; k++) begin
            ram[k] = ram_fill(k);
        end
        load_program();
        build_expected();
        cycle_limit = 10 * prog_len + max_ack_wait + reset_cycles;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (mreq == 1'b0) else begin
            other_errors++;
            $display("error mreq got %h expected %h", mreq, 1'b0);
        end
        assert (write == 1'b0) else begin
            other_errors++;
            $display("error write got %h expected %h", write, 1'b0);
        end
        assert (iad == rv_pkg::reset_pc) else begin
            other_errors++;
            $display("error iad got %h expected %h", iad, rv_pkg::reset_pc);
        end
        wait (st_idx == n_exp && iad == halt_pc);
        // Drain the five stages so a late extra store would still show
        mark = adv_count;
        wait (adv_count >= mark + 5);
        finish_run();
    end

    initial begin
        wait (cycle_limit > 0);
        wait (cycles >= cycle_limit);
        other_errors++;
        $display("timeout after %0d cycles with %0d of %0d stores seen", cycles, st_idx, n_exp);
        finish_run();
    end

endmodule

//--- list.f
rv_pkg.sv
if_stage.sv
id_stage.sv
rf32x32.sv
ex_stage.sv
mem_stage.sv
hazard_unit.sv
top.sv
tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP BUILD_DIR LOG FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
